// File: hw/ahb_burst_pkg.sv
package ahb_burst_pkg;

    // hburst encoding, only the word bursts this master issues
    typedef enum logic [2:0] {
        SINGLE = 3'd0,
        WRAP4  = 3'd2,
        INCR4  = 3'd3
    } burst_types;

    // htrans encoding as on the bus
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        BUSY   = 2'd1, // never driven by this master
        NONSEQ = 2'd2,
        SEQ    = 2'd3
    } trans_types;

    // address step between two beats of a word burst
    localparam int WORD_BYTES = 4;

    // clears the low four bits to find the 16-byte block of a WRAP4
    localparam logic [31:0] WRAP4_BLOCK_MASK = 32'hFFFF_FFF0;

    // write words carried by one command
    localparam int BEATS_MAX = 4;

endpackage

// File: hw/ahb_cmd_capture.sv
module ahb_cmd_capture
    import ahb_burst_pkg::*;
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      start,
    input  logic [31:0]               cmd_addr,
    input  logic                      cmd_write,
    input  burst_types                cmd_burst,
    input  logic [BEATS_MAX*32-1:0]   cmd_wdata,
    input  logic                      done,
    output logic                      busy,
    output logic                      launch,
    output logic [31:0]               cur_addr,
    output logic                      cur_write,
    output burst_types                cur_burst,
    output logic [BEATS_MAX*32-1:0]   cur_wdata
);

    logic accept;

    assign accept = start && !busy; // a start during a burst is dropped on purpose

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy   <= 1'b0;
            launch <= 1'b0;
        end else begin
            launch <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0; // drops the cycle after the done pulse
            end
        end
    end

    // held fields stay put until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_addr  <= {cmd_addr[31:2], 2'b00}; // word transfers only
            cur_write <= cmd_write;
            cur_burst <= cmd_burst;
            cur_wdata <= cmd_wdata;
        end
    end

endmodule

// File: hw/ahb_burst_addr_gen.sv
module ahb_burst_addr_gen
    import ahb_burst_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        launch,
    input  logic [31:0] cur_addr,
    input  logic        cur_write,
    input  burst_types  cur_burst,
    input  logic        hready,
    output logic [31:0] haddr,
    output trans_types  htrans,
    output logic        hwrite,
    output burst_types  hburst,
    output logic [1:0]  beat_idx,
    output logic        last_beat
);

    trans_types  trans_q;
    logic [31:0] addr_q;
    logic [1:0]  cnt_q;
    logic [31:0] base_q;
    logic [3:0]  offset_q;
    logic [31:0] base_now;
    logic [3:0]  offset_now;
    logic [3:0]  offset_next;
    logic [31:0] addr_next;
    logic [1:0]  last_idx;
    logic        accepted;

    // the launch cycle already shows the first NONSEQ, registers take over after it
    assign htrans     = launch ? NONSEQ : trans_q;
    assign haddr      = launch ? cur_addr : addr_q;
    assign beat_idx   = launch ? 2'd0 : cnt_q;
    assign base_now   = launch ? (cur_addr & WRAP4_BLOCK_MASK) : base_q;
    assign offset_now = launch ? cur_addr[3:0] : offset_q;

    assign hwrite = cur_write;
    assign hburst = cur_burst;

    assign last_idx  = (cur_burst == SINGLE) ? 2'd0 : 2'(BEATS_MAX - 1);
    assign last_beat = (beat_idx == last_idx);
    assign accepted  = hready && (htrans == NONSEQ || htrans == SEQ);

    assign offset_next = offset_now + 4'(WORD_BYTES); // wraps at 16 by width

    always_comb begin
        case (cur_burst)
            WRAP4: begin
                addr_next = base_now | {28'd0, offset_next};
            end
            default: begin
                addr_next = haddr + 32'(WORD_BYTES);
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            trans_q <= IDLE;
            addr_q  <= '0;
            cnt_q   <= '0;
        end else if (accepted) begin
            if (last_beat) begin
                trans_q <= IDLE; // burst fully issued
                addr_q  <= haddr;
                cnt_q   <= '0;
            end else begin
                trans_q <= SEQ;
                addr_q  <= addr_next;
                cnt_q   <= beat_idx + 2'd1;
            end
        end else begin
            // hready low or nothing to issue, so the address phase holds
            trans_q <= htrans;
            addr_q  <= haddr;
            cnt_q   <= beat_idx;
        end
    end

    // wrap base and offset follow the beat in the address phase
    always_ff @(posedge clk) begin
        base_q   <= base_now;
        offset_q <= accepted ? offset_next : offset_now;
    end

endmodule

// File: hw/ahb_data_phase.sv
module ahb_data_phase
    import ahb_burst_pkg::*;
(
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      hready,
    input  trans_types                htrans,
    input  logic [31:0]               haddr,
    input  logic                      hwrite,
    input  logic [1:0]                beat_idx,
    input  logic                      last_beat,
    input  logic [BEATS_MAX*32-1:0]   cur_wdata,
    input  logic [31:0]               hrdata,
    output logic [31:0]               hwdata,
    output logic                      rd_valid,
    output logic [31:0]               rd_addr,
    output logic [31:0]               rd_data,
    output logic                      done
);

    logic        dp_valid;
    logic [31:0] dp_addr;
    logic        dp_write;
    logic [1:0]  dp_idx;
    logic        dp_last;
    logic        accepted;
    logic        complete;

    assign accepted = hready && (htrans == NONSEQ || htrans == SEQ);
    assign complete = hready && dp_valid; // data phase ends on the first ready edge

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= complete && dp_last;
            if (hready) begin
                dp_valid <= accepted; // the next beat moves in as this one leaves
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            dp_addr  <= haddr;
            dp_write <= hwrite;
            dp_idx   <= beat_idx;
            dp_last  <= last_beat;
        end
    end

    // word k of the command goes out with the k-th issued beat
    assign hwdata = (dp_valid && dp_write) ? cur_wdata[{dp_idx, 5'b0} +: 32] : '0;

    assign rd_valid = complete && !dp_write;
    assign rd_addr  = dp_addr;
    assign rd_data  = hrdata;

endmodule

// File: hw/ahb_sram_slave.sv
module ahb_sram_slave
    import ahb_burst_pkg::*;
#(
    parameter int MEM_WORDS_LOG2 = 6,
    parameter int WAIT_STATES    = 1
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] haddr,
    input  trans_types  htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    output logic        hready,
    output logic [31:0] hrdata
);

    localparam int WAIT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]               mem [2**MEM_WORDS_LOG2];
    logic                      pend;
    logic [WAIT_W-1:0]         wait_cnt;
    logic [MEM_WORDS_LOG2-1:0] p_idx;
    logic                      p_write;
    logic                      accepted;

    assign hready   = !pend || (wait_cnt == '0);
    assign accepted = hready && (htrans == NONSEQ || htrans == SEQ);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend     <= 1'b0;
            wait_cnt <= '0;
        end else if (hready) begin
            pend     <= accepted;
            wait_cnt <= accepted ? WAIT_W'(WAIT_STATES) : '0;
        end else begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hready && accepted) begin
            p_idx   <= haddr[MEM_WORDS_LOG2+1:2]; // upper bits dropped, so it wraps
            p_write <= hwrite;
        end
    end

    // write lands on the edge that finishes the data phase
    always_ff @(posedge clk) begin
        if (pend && hready && p_write) begin
            mem[p_idx] <= hwdata;
        end
    end

    assign hrdata = (pend && !p_write) ? mem[p_idx] : '0;

endmodule

// File: hw/ahb_burst_top.sv
module ahb_burst_top
    import ahb_burst_pkg::*;
#(
    parameter int MEM_WORDS_LOG2 = 6,
    parameter int WAIT_STATES    = 1
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      start,
    input  logic [31:0]               cmd_addr,
    input  logic                      cmd_write,
    input  burst_types                cmd_burst,
    input  logic [BEATS_MAX*32-1:0]   cmd_wdata,
    output logic                      busy,
    output logic                      rd_valid,
    output logic [31:0]               rd_addr,
    output logic [31:0]               rd_data,
    output logic                      done
);

    logic                    launch;
    logic [31:0]             cur_addr;
    logic                    cur_write;
    burst_types              cur_burst;
    logic [BEATS_MAX*32-1:0] cur_wdata;
    logic [31:0]             haddr;
    trans_types              htrans;
    logic                    hwrite;
    logic [1:0]              beat_idx;
    logic                    last_beat;
    logic                    hready;
    logic [31:0]             hrdata;
    logic [31:0]             hwdata;

    ahb_cmd_capture ahb_cmd_capture_i (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .cmd_addr  (cmd_addr),
        .cmd_write (cmd_write),
        .cmd_burst (cmd_burst),
        .cmd_wdata (cmd_wdata),
        .done      (done),
        .busy      (busy),
        .launch    (launch),
        .cur_addr  (cur_addr),
        .cur_write (cur_write),
        .cur_burst (cur_burst),
        .cur_wdata (cur_wdata)
    );

    ahb_burst_addr_gen ahb_burst_addr_gen_i (
        .clk       (clk),
        .rstn      (rstn),
        .launch    (launch),
        .cur_addr  (cur_addr),
        .cur_write (cur_write),
        .cur_burst (cur_burst),
        .hready    (hready),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hburst    (),
        .beat_idx  (beat_idx),
        .last_beat (last_beat)
    );

    ahb_data_phase ahb_data_phase_i (
        .clk       (clk),
        .rstn      (rstn),
        .hready    (hready),
        .htrans    (htrans),
        .haddr     (haddr),
        .hwrite    (hwrite),
        .beat_idx  (beat_idx),
        .last_beat (last_beat),
        .cur_wdata (cur_wdata),
        .hrdata    (hrdata),
        .hwdata    (hwdata),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .done      (done)
    );

    ahb_sram_slave #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .WAIT_STATES    (WAIT_STATES)
    ) ahb_sram_slave_i (
        .clk    (clk),
        .rstn   (rstn),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hready (hready),
        .hrdata (hrdata)
    );

endmodule

// File: verification/tb_ahb_burst.sv
module tb_ahb_burst
    import ahb_burst_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS_LOG2 = 6;
    localparam int TIMEOUT_CYCLES = 200;

    logic         clk;
    logic         rstn;
    logic         start;
    logic [31:0]  cmd_addr;
    logic         cmd_write;
    burst_types   cmd_burst;
    logic [127:0] cmd_wdata;
    logic         busy;
    logic         rd_valid;
    logic [31:0]  rd_addr;
    logic [31:0]  rd_data;
    logic         done;

    logic [31:0] model_mem [2**MEM_WORDS_LOG2];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] trace_data_q [$];
    int          rd_count;
    int          done_count;
    int          exp_rd;
    int          data_errors;
    int          addr_errors;
    int          count_errors;
    int          other_errors;

    ahb_burst_top #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .WAIT_STATES    (1)
    ) ahb_burst_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .cmd_addr  (cmd_addr),
        .cmd_write (cmd_write),
        .cmd_burst (cmd_burst),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .done      (done)
    );

    always #50 clk = ~clk;

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            data_errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            addr_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
            count_errors++;
        end
    endtask

    function automatic int beat_count(input burst_types kind);
        return (kind == SINGLE) ? 1 : 4;
    endfunction

    // WRAP4 keeps the 16-byte block and wraps the offset inside it
    function automatic logic [31:0] beat_addr(input burst_types kind, input logic [31:0] addr,
                                              input int k);
        logic [31:0] step;
        step = 32'(k * 4);
        if (kind == WRAP4) begin
            return (addr & 32'hFFFF_FFF0) | ((addr + step) & 32'h0000_000F);
        end
        return addr + step;
    endfunction

    function automatic logic [MEM_WORDS_LOG2-1:0] mem_index(input logic [31:0] addr);
        return addr[MEM_WORDS_LOG2+1:2];
    endfunction

    task automatic wait_done();
        int  n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            seen = done;
            n++;
        end
        if (!seen) begin
            $display("%0t: timed out waiting for done", $time);
            other_errors++;
        end
    endtask

    task automatic wait_idle();
        int  n;
        logic idle;
        n = 0;
        idle = 1'b0;
        while (!idle && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            idle = !busy;
            n++;
        end
        if (!idle) begin
            $display("%0t: timed out waiting for busy to fall", $time);
            other_errors++;
        end
    endtask

    task automatic run_command(input logic write, input burst_types kind,
                               input logic [31:0] addr, input logic [127:0] words,
                               input logic ghost);
        int          beats;
        logic [31:0] baddr;
        logic [31:0] word;
        beats = beat_count(kind);
        wait_idle();
        for (int k = 0; k < beats; k++) begin
            baddr = beat_addr(kind, addr, k);
            word = words[k*32 +: 32];
            if (write) begin
                model_mem[mem_index(baddr)] = word;
            end else begin
                exp_addr_q.push_back(baddr);
                exp_data_q.push_back(model_mem[mem_index(baddr)]);
                trace_data_q.push_back(word);
            end
        end
        @(posedge clk);
        rd_count = 0;
        done_count = 0;
        exp_rd = write ? 0 : beats;
        start     <= 1'b1;
        cmd_addr  <= addr;
        cmd_write <= write;
        cmd_burst <= kind;
        cmd_wdata <= words;
        @(posedge clk);
        start <= 1'b0;
        if (ghost) begin
            @(negedge clk);
            if (!busy) begin
                $display("%0t: busy was low when the start to be ignored was sent", $time);
                other_errors++;
            end
            @(posedge clk);
            start     <= 1'b1; // must be dropped, the burst above is still running
            cmd_addr  <= addr ^ 32'h0000_0080;
            cmd_write <= !write;
            cmd_burst <= INCR4;
            cmd_wdata <= ~words;
            @(posedge clk);
            start <= 1'b0;
        end
        wait_done();
        wait_idle();
        repeat (3) @(posedge clk); // room for any stray strobe to show up
        check_count("rd_valid", exp_rd, rd_count);
        check_count("done", 1, done_count);
    endtask

    // read beats and done are sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (rstn && rd_valid) begin
            rd_count = rd_count + 1;
            if (exp_addr_q.size() == 0) begin
                $display("%0t: rd_valid arrived with no read beat expected", $time);
                other_errors++;
            end else begin
                check_addr("rd_addr", exp_addr_q.pop_front(), rd_addr);
                check_word("rd_data", exp_data_q.pop_front(), rd_data);
                check_word("rd_data trace", trace_data_q.pop_front(), rd_data);
            end
        end
        if (rstn && done) begin
            done_count = done_count + 1;
            check_count("rd_valid before done", exp_rd, rd_count);
        end
    end

    initial begin
        int          fd;
        int          fields;
        int          wr;
        int          kind;
        int          ghost;
        string       line;
        logic [31:0] addr;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] d3;
        clk = 1'b0;
        rstn = 1'b0;
        start = 1'b0;
        cmd_addr = '0;
        cmd_write = 1'b0;
        cmd_burst = SINGLE;
        cmd_wdata = '0;
        rd_count = 0;
        done_count = 0;
        exp_rd = 0;
        data_errors = 0;
        addr_errors = 0;
        count_errors = 0;
        other_errors = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        fd = $fopen("verification/ahb_burst_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                     wr, kind, addr, d0, d1, d2, d3, ghost);
                    if (fields != 8) begin
                        $display("malformed trace line: %s", line);
                        other_errors++;
                    end else begin
                        run_command(wr != 0, burst_types'(kind), addr,
                                    {d3, d2, d1, d0}, ghost != 0);
                    end
                end
            end
            $fclose(fd);
        end
        if (exp_addr_q.size() != 0) begin
            $display("%0d expected read beats never arrived", exp_addr_q.size());
            other_errors++;
        end
        $display("errors: data %0d, address %0d, count %0d, other %0d",
                 data_errors, addr_errors, count_errors, other_errors);
        if (data_errors + addr_errors + count_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hw/ahb_burst_pkg.sv
hw/ahb_cmd_capture.sv
hw/ahb_burst_addr_gen.sv
hw/ahb_data_phase.sv
hw/ahb_sram_slave.sv
hw/ahb_burst_top.sv
verification/tb_ahb_burst.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ahb_burst -f verilog.f -o tb_ahb_burst \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_ahb_burst)
echo "$sim_out"
grep -qx "Test completed successfully" <<< "$sim_out" && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }

// File: verification/ahb_burst_trace.txt
# write burst(0 SINGLE, 2 WRAP4, 3 INCR4) addr word0 word1 word2 word3 busy_start
# write lines carry beat data in issue order, read lines the expected data per beat
1 0 00000010 a5a50001 00000000 00000000 00000000 0
0 0 00000010 a5a50001 00000000 00000000 00000000 0
1 3 00000040 11110000 11110004 11110008 1111000c 0
0 3 00000040 11110000 11110004 11110008 1111000c 0
1 2 00000028 22220028 2222002c 22220020 22220024 0
0 2 00000028 22220028 2222002c 22220020 22220024 0
0 3 00000020 22220020 22220024 22220028 2222002c 0
0 0 00000010 a5a50001 00000000 00000000 00000000 1
0 0 00000148 11110008 00000000 00000000 00000000 0
1 2 00000034 3333aaaa 3333bbbb 3333cccc 3333dddd 1
0 3 00000030 3333dddd 3333aaaa 3333bbbb 3333cccc 0
0 2 0000003c 3333cccc 3333dddd 3333aaaa 3333bbbb 1
1 3 00000038 44440038 4444003c 44440040 44440044 0
0 3 00000038 44440038 4444003c 44440040 44440044 0
0 3 00000040 44440040 44440044 11110008 1111000c 0
1 0 000000fc 55550fc0 00000000 00000000 00000000 0
0 0 000000fc 55550fc0 00000000 00000000 00000000 1
1 2 00000000 66660000 66660004 66660008 6666000c 0
0 3 00000000 66660000 66660004 66660008 6666000c 0
0 2 00000008 66660008 6666000c 66660000 66660004 0
1 0 00000010 77770010 00000000 00000000 00000000 1
0 0 00000010 77770010 00000000 00000000 00000000 0
